/* Bender.yml */
package:
  name: axil_axis_writer

sources:
  - include_dirs:
      - .
    files:
      - axis_writer_pkg.sv
      - write_req_if.sv
      - input_buffer.sv
      - axil_write_intake.sv
      - axis_word_emitter.sv
      - axil_write_response.sv
      - axil_axis_writer_top.sv
      - target: test
        files:
          - tb_axil_axis_writer.sv

/* axil_axis_writer_top.sv */
`include "axis_writer_defs.svh"

module axil_axis_writer_top (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  logic [`AXI_ADDR_WIDTH-1:0]   s_axi_awaddr,
  input  logic                       s_axi_awvalid,
  output logic                       s_axi_awready,
  input  logic [`AXI_DATA_WIDTH-1:0]   s_axi_wdata,
  input  logic [`AXI_DATA_WIDTH/8-1:0] s_axi_wstrb,
  input  logic                       s_axi_wvalid,
  output logic                       s_axi_wready,
  output logic [1:0]                 s_axi_bresp,
  output logic                       s_axi_bvalid,
  input  logic                       s_axi_bready,
  input  logic [`AXI_ADDR_WIDTH-1:0]   s_axi_araddr,
  input  logic                       s_axi_arvalid,
  output logic                       s_axi_arready,
  output logic [`AXI_DATA_WIDTH-1:0]   s_axi_rdata,
  output logic [1:0]                 s_axi_rresp,
  output logic                       s_axi_rvalid,
  input  logic                       s_axi_rready,
  output logic [`AXI_DATA_WIDTH-1:0]   m_axis_tdata,
  output logic                       m_axis_tvalid
);
  import axis_writer_pkg::*;

  wbeat_t wbeat;       // W channel payload
  resp_t  resp;        // Emitter response
  logic   resp_valid;
  logic   resp_ready;
  resp_t  bresp;       // Held B response

  // Read channel stays idle
  wire                       rd_arready = 1'b0;
  wire                       rd_rvalid  = 1'b0;
  wire [`AXI_DATA_WIDTH-1:0] rd_rdata   = '0;
  wire [1:0]                 rd_rresp   = 2'b00;

  write_req_if req_if ();

  assign wbeat.strb = s_axi_wstrb;
  assign wbeat.data = s_axi_wdata;

  axil_write_intake axil_write_intake_inst (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .awaddr  (s_axi_awaddr),
    .awvalid (s_axi_awvalid),
    .awready (s_axi_awready),
    .wbeat   (wbeat),
    .wvalid  (s_axi_wvalid),
    .wready  (s_axi_wready),
    .req     (req_if.src)
  );

  axis_word_emitter axis_word_emitter_inst (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .req        (req_if.dst),
    .tdata      (m_axis_tdata),
    .tvalid     (m_axis_tvalid),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
  );

  axil_write_response axil_write_response_inst (
    .aclk       (aclk),
    .rst_n      (rst_n),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .bresp      (bresp),
    .bvalid     (s_axi_bvalid),
    .bready     (s_axi_bready)
  );

  assign s_axi_bresp = bresp;

  assign s_axi_arready = rd_arready;
  assign s_axi_rvalid  = rd_rvalid;
  assign s_axi_rdata   = rd_rdata;
  assign s_axi_rresp   = rd_rresp;

endmodule

/* axil_write_intake.sv */
module axil_write_intake (
  input  logic                    aclk,
  input  logic                    rst_n,
  input  axis_writer_pkg::addr_t  awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  axis_writer_pkg::wbeat_t wbeat,
  input  logic                    wvalid,
  output logic                    wready,
  write_req_if.src                req
);
  import axis_writer_pkg::*;

  addr_t  aw_data;   // Buffered address
  logic   aw_valid;
  logic   aw_take;   // Address leaves its buffer
  wbeat_t w_data;    // Buffered data beat
  logic   w_valid;
  logic   w_take;    // Data beat leaves its buffer

  input_buffer #(
    .payload_t (addr_t)
  ) aw_buf (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_data   (awaddr),
    .in_valid  (awvalid),
    .in_ready  (awready),
    .out_data  (aw_data),
    .out_valid (aw_valid),
    .out_ready (aw_take)
  );

  input_buffer #(
    .payload_t (wbeat_t)
  ) w_buf (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .in_data   (wbeat),
    .in_valid  (wvalid),
    .in_ready  (wready),
    .out_data  (w_data),
    .out_valid (w_valid),
    .out_ready (w_take)
  );

  // A half is released only together with its partner
  assign aw_take = w_valid && req.ready;
  assign w_take  = aw_valid && req.ready;

  assign req.addr  = aw_data;
  assign req.beat  = w_data;
  assign req.valid = aw_valid && w_valid;  // Pair complete

endmodule

/* axil_write_response.sv */
module axil_write_response (
  input  logic                   aclk,
  input  logic                   rst_n,
  input  axis_writer_pkg::resp_t resp,
  input  logic                   resp_valid,
  output logic                   resp_ready,
  output axis_writer_pkg::resp_t bresp,
  output logic                   bvalid,
  input  logic                   bready
);
  import axis_writer_pkg::*;

  resp_t resp_reg;   // Response shown on B
  logic  resp_full;  // B beat pending

  // Empty, or the pending beat is taken this edge
  assign resp_ready = !resp_full || bready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      resp_full <= 1'b0;
    end else if (resp_valid && resp_ready) begin
      resp_full <= 1'b1;
    end else if (bready) begin
      resp_full <= 1'b0;  // Master took the beat, nothing new
    end
  end

  always_ff @(posedge aclk) begin
    if (resp_valid && resp_ready) begin
      resp_reg <= resp;
    end
  end

  assign bresp  = resp_reg;
  assign bvalid = resp_full;

endmodule

/* axis_word_emitter.sv */
`include "axis_writer_defs.svh"

module axis_word_emitter (
  input  logic                   aclk,
  input  logic                   rst_n,
  write_req_if.dst               req,
  output axis_writer_pkg::data_t tdata,
  output logic                   tvalid,
  output axis_writer_pkg::resp_t resp,
  output logic                   resp_valid,
  input  logic                   resp_ready
);
  import axis_writer_pkg::*;

  localparam int    byte_count  = `AXI_DATA_WIDTH / 8;
  localparam int    addr_lsb    = $clog2(byte_count);     // Byte offset bits
  localparam addr_t stream_addr = `STREAM_ADDR;

  data_t held_word;  // Last word sent on the stream
  data_t merged;     // Held word with strobed bytes replaced
  logic  hit;        // Request targets the stream word
  logic  take;       // Request consumed this edge

  // Word-aligned address match
  assign hit = req.addr[`AXI_ADDR_WIDTH-1:addr_lsb] ==
               stream_addr[`AXI_ADDR_WIDTH-1:addr_lsb];

  always_comb begin
    merged = held_word;
    for (int i = 0; i < byte_count; i++) begin
      if (req.beat.strb[i]) begin
        merged[8*i +: 8] = req.beat.data[8*i +: 8];
      end
    end
  end

  // Stall while the response holder is busy
  assign req.ready = resp_ready;
  assign take      = req.valid && resp_ready;

  assign tdata  = merged;
  assign tvalid = take && hit;  // One-cycle strobe per stream write

  assign resp       = hit ? RESP_OKAY : RESP_SLVERR;
  assign resp_valid = req.valid;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      held_word <= '0;
    end else if (take && hit) begin
      held_word <= merged;
    end
  end

endmodule

/* axis_writer_defs.svh */
`ifndef AXIS_WRITER_DEFS_SVH
`define AXIS_WRITER_DEFS_SVH

// AXI4-Lite address bus width in bits
`define AXI_ADDR_WIDTH 16

// AXI4-Lite data bus width in bits, also the stream word width
`define AXI_DATA_WIDTH 32

// Byte address whose word feeds the stream
`define STREAM_ADDR 16'h0000

`endif

/* axis_writer_pkg.sv */
`include "axis_writer_defs.svh"

package axis_writer_pkg;

  typedef logic [`AXI_ADDR_WIDTH-1:0]   addr_t;  // Write address
  typedef logic [`AXI_DATA_WIDTH-1:0]   data_t;  // Data word
  typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;  // One strobe per byte

  // Payload of one W beat
  typedef struct packed {
    strb_t strb;
    data_t data;
  } wbeat_t;

  // AXI write response codes in use here
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } resp_t;

endpackage

/* filelist.f */
+incdir+.
axis_writer_pkg.sv
write_req_if.sv
input_buffer.sv
axil_write_intake.sv
axis_word_emitter.sv
axil_write_response.sv
axil_axis_writer_top.sv
tb_axil_axis_writer.sv

/* input_buffer.sv */
module input_buffer #(
  parameter type payload_t = axis_writer_pkg::data_t
) (
  input  logic     aclk,
  input  logic     rst_n,
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);
  import axis_writer_pkg::*;

  logic     full;      // Entry holds a beat
  payload_t data_reg;  // Stored beat

  // Room when empty or when the stored beat leaves this edge
  assign in_ready = !full || out_ready;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;  // Refill, possibly as the old beat leaves
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (in_valid && in_ready) begin
      data_reg <= in_data;
    end
  end

  assign out_data  = data_reg;
  assign out_valid = full;

endmodule

/* tb_axil_axis_writer.sv */
`include "axis_writer_defs.svh"

module tb_axil_axis_writer;
  timeunit 1ns;
  timeprecision 1ps;
  import axis_writer_pkg::*;

  localparam int num_writes     = 400;
  localparam int byte_count     = `AXI_DATA_WIDTH / 8;
  localparam int addr_lsb       = $clog2(byte_count);
  localparam int pat_len        = 256;
  localparam int timeout_cycles = 20 * num_writes + 100;

  logic                         aclk = 1'b0;
  logic                         rst_n;
  addr_t                        s_axi_awaddr;
  logic                         s_axi_awvalid;
  logic                         s_axi_awready;
  data_t                        s_axi_wdata;
  strb_t                        s_axi_wstrb;
  logic                         s_axi_wvalid;
  logic                         s_axi_wready;
  logic [1:0]                   s_axi_bresp;
  logic                         s_axi_bvalid;
  logic                         s_axi_bready;
  addr_t                        s_axi_araddr;
  logic                         s_axi_arvalid;
  logic                         s_axi_arready;
  data_t                        s_axi_rdata;
  logic [1:0]                   s_axi_rresp;
  logic                         s_axi_rvalid;
  logic                         s_axi_rready;
  data_t                        m_axis_tdata;
  logic                         m_axis_tvalid;

  logic [31:0] rng_state = 32'd26;
  addr_t       wr_addr [num_writes];
  data_t       wr_data [num_writes];
  strb_t       wr_strb [num_writes];
  int          aw_gap  [num_writes];  // Idle cycles before each AW beat
  int          w_gap   [num_writes];
  logic [31:0] side_pat [pat_len];    // bready, rready and AR activity per cycle
  data_t       exp_words [$];
  resp_t       exp_resps [$];
  int          resp_count  = 0;
  int          cycle_count = 0;

  axil_axis_writer_top axil_axis_writer_top_inst (.*);

  always #10 aclk = ~aclk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic targets_stream(input addr_t a);
    return (a >> addr_lsb) == (addr_t'(`STREAM_ADDR) >> addr_lsb);
  endfunction

  task automatic stop_on_failure();
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_word(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_resp(input string name, input resp_t got, input resp_t exp);
    if (got !== exp) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("error %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_on_failure();
    end
  endtask

  // Draws all stimulus up front and fills the expected queues
  task automatic generate_writes();
    int    i;
    data_t model_word;
    model_word = '0;
    for (i = 0; i < num_writes; i++) begin
      if ((i % 40) < 8) begin  // Run of single-byte writes
        wr_addr[i] = `STREAM_ADDR;
        wr_strb[i] = strb_t'(1 << (i % byte_count));
      end else begin
        wr_addr[i] = (next_random() % 10 < 7) ? addr_t'(`STREAM_ADDR) : addr_t'(next_random());
        wr_strb[i] = strb_t'(next_random());
      end
      wr_data[i] = data_t'(next_random());
      aw_gap[i]  = next_random() % 4;
      w_gap[i]   = next_random() % 4;
      if (targets_stream(wr_addr[i])) begin
        for (int b = 0; b < byte_count; b++) begin
          if (wr_strb[i][b]) model_word[8*b +: 8] = wr_data[i][8*b +: 8];
        end
        exp_words.push_back(model_word);
        exp_resps.push_back(RESP_OKAY);
      end else begin
        exp_resps.push_back(RESP_SLVERR);
      end
    end
    for (i = 0; i < pat_len; i++) begin
      side_pat[i] = next_random();
    end
  endtask

  task automatic drive_aw();
    logic accepted;
    for (int i = 0; i < num_writes; i++) begin
      repeat (aw_gap[i]) begin
        @(posedge aclk);
        #2;
      end
      s_axi_awaddr  = wr_addr[i];
      s_axi_awvalid = 1'b1;
      accepted      = 1'b0;
      while (!accepted) begin
        @(negedge aclk);
        accepted = s_axi_awready;  // Stable until the next edge
        @(posedge aclk);
        #2;
      end
      s_axi_awvalid = 1'b0;
    end
  endtask

  task automatic drive_w();
    logic accepted;
    for (int i = 0; i < num_writes; i++) begin
      repeat (w_gap[i]) begin
        @(posedge aclk);
        #2;
      end
      s_axi_wdata  = wr_data[i];
      s_axi_wstrb  = wr_strb[i];
      s_axi_wvalid = 1'b1;
      accepted     = 1'b0;
      while (!accepted) begin
        @(negedge aclk);
        accepted = s_axi_wready;
        @(posedge aclk);
        #2;
      end
      s_axi_wvalid = 1'b0;
    end
  endtask

  task automatic drive_side_inputs();
    int idx;
    idx = 0;
    forever begin
      s_axi_bready  = side_pat[idx][0] | side_pat[idx][1];  // High about 75% of cycles
      s_axi_rready  = side_pat[idx][2];
      s_axi_arvalid = side_pat[idx][3];
      s_axi_araddr  = side_pat[idx][19:4];
      idx = (idx + 1) % pat_len;
      @(posedge aclk);
      #2;
    end
  endtask

  // Outputs are sampled mid-cycle, away from the driving edge
  always @(negedge aclk) begin
    if (rst_n) begin
      check_bit("s_axi_arready", s_axi_arready, 1'b0);
      check_bit("s_axi_rvalid", s_axi_rvalid, 1'b0);
      check_word("s_axi_rdata", s_axi_rdata, '0);
      check_resp("s_axi_rresp", resp_t'(s_axi_rresp), RESP_OKAY);
      if (m_axis_tvalid) begin
        if (exp_words.size() == 0) begin
          $display("unexpected stream word 0x%0h with no stream write pending", m_axis_tdata);
          stop_on_failure();
        end else begin
          check_word("m_axis_tdata", m_axis_tdata, exp_words.pop_front());
        end
      end
      if (s_axi_bvalid && s_axi_bready) begin
        if (exp_resps.size() == 0) begin
          $display("unexpected write response with no write pending");
          stop_on_failure();
        end else begin
          check_resp("s_axi_bresp", resp_t'(s_axi_bresp), exp_resps.pop_front());
          resp_count++;
        end
      end
    end
  end

  always @(posedge aclk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles with %0d of %0d responses seen",
               cycle_count, resp_count, num_writes);
      stop_on_failure();
    end
  end

  initial begin
    rst_n         = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_bready  = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready  = 1'b0;
    generate_writes();
    repeat (2) @(posedge aclk);
    #2;
    rst_n = 1'b1;
    @(negedge aclk);
    check_bit("s_axi_bvalid", s_axi_bvalid, 1'b0);
    check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
    check_bit("s_axi_awready", s_axi_awready, 1'b1);
    check_bit("s_axi_wready", s_axi_wready, 1'b1);
    @(posedge aclk);
    #2;
    fork
      drive_aw();
      drive_w();
      drive_side_inputs();
    join_none
    wait (resp_count == num_writes);
    repeat (4) @(posedge aclk);  // Catch any stray strobe after the last response
    if (exp_words.size() == 0 && exp_resps.size() == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("%0d stream words and %0d responses still expected at the end",
               exp_words.size(), exp_resps.size());
      stop_on_failure();
    end
  end

endmodule

/* write_req_if.sv */
interface write_req_if;
  import axis_writer_pkg::*;

  addr_t  addr;   // Address of the paired request
  wbeat_t beat;   // Data and strobes of the paired request
  logic   valid;  // Both halves present
  logic   ready;  // Consumer takes the request

  modport src (
    output addr,
    output beat,
    output valid,
    input  ready
  );

  modport dst (
    input  addr,
    input  beat,
    input  valid,
    output ready
  );

endinterface
